//--- vlog.f
+incdir+common
+incdir+sim
common/core_pkg.sv
logic/regfile.sv
logic/immExtend.sv
logic/alu.sv
datapath/datapath.sv
controller/controller.sv
logic/intCore.sv
sim/intCoreTb.sv

//--- sim/intCoreRef.svh
`ifndef INTCORE_REF_SVH
`define INTCORE_REF_SVH

// Expected writeback of one instruction, with the legality of its encoding
typedef struct packed {
  logic              legal;
  logic [`REGAW-1:0] rd;
  logic [`XLEN-1:0]  data;
} expWb_t;

// Architectural registers, updated in program order
logic [`XLEN-1:0] modelRegs [0:`NREGS-1];

function automatic void modelReset();
  for (int i = 0; i < `NREGS; i++) modelRegs[i] = '0;
endfunction

// RV32I semantics for LUI, OP and OP-IMM, straight from the ISA
function automatic expWb_t refExecute(input logic [31:0] word);
  expWb_t           res;
  logic [6:0]       opcode;
  logic [6:0]       funct7;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic             f7Checked;   // funct7 field must hold a known pattern
  logic             altAllowed;  // 0x20 is meaningful here

  opcode    = word[6:0];
  funct3    = word[14:12];
  funct7    = word[31:25];
  a         = modelRegs[word[19:15]];
  b         = (opcode == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : modelRegs[word[24:20]];
  res.legal = 1'b1;
  res.rd    = word[11:7];
  res.data  = '0;

  if (opcode == 7'b0110111) begin
    res.data = {word[31:12], 12'h000};  // LUI
  end else if (opcode == 7'b0110011 || opcode == 7'b0010011) begin
    f7Checked  = (opcode == 7'b0110011) || (funct3 == 3'd1) || (funct3 == 3'd5);
    altAllowed = (funct3 == 3'd5) || (opcode == 7'b0110011 && funct3 == 3'd0);
    if (f7Checked && !(funct7 == 7'h00 || (funct7 == 7'h20 && altAllowed)))
      res.legal = 1'b0;
    case (funct3)
      3'd0: res.data = (opcode == 7'b0110011 && funct7[5]) ? a - b : a + b;
      3'd1: res.data = a << b[4:0];
      3'd2: res.data = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'd3: res.data = {{(`XLEN-1){1'b0}}, a < b};
      3'd4: res.data = a ^ b;
      3'd5: begin
        if (funct7[5])
          res.data = $signed(a) >>> b[4:0];  // Arithmetic
        else
          res.data = a >> b[4:0];
      end
      3'd6: res.data = a | b;
      default: res.data = a & b;
    endcase
  end else begin
    res.legal = 1'b0;  // Loads, branches, system and the rest
  end

  if (res.legal && res.rd != '0)
    modelRegs[res.rd] = res.data;  // x0 stays zero
  return res;
endfunction

`endif

//--- sim/intCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module intCoreTb;
  import core_pkg::*;

  `include "intCoreRef.svh"

  logic              clk;
  logic              rst;
  logic              instrValid;
  logic              hold;
  instrWord_u        instr;
  logic              wbValid;
  logic [`REGAW-1:0] wbRd;
  logic [`XLEN-1:0]  wbData;
  logic              illegal;

  expWb_t expQ [$];            // Outstanding writebacks, oldest first
  int     seed = 32'ha9fa1605;
  int     holdPct;             // Chance of a hold cycle before each word
  int     errors, checks;
  int     sent, holdCycles, gapCycles, cycles;
  int     illegalSent, illegalSeen;
  int     testsRun, testsFailed;
  int     errStart, sentStart;

  intCore intCore_inst (
    .clk, .rst, .instrValid, .instr, .hold,
    .wbValid, .wbRd, .wbData, .illegal
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Encoders and stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iOp(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd, rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm20);
    return {imm20, rd, 7'b0110111};
  endfunction

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Any supported form, operand registers given
  function automatic logic [31:0] randInstr(input logic [4:0] rd, rs1, rs2);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    r   = $random(seed);
    f3  = r[2:0];
    imm = r[31:20];
    if (r[4:3] == 2'b00)
      return lui(rd, r[31:12]);
    if (r[4:3] == 2'b01) begin
      if (f3 == 3'd1 || f3 == 3'd5)
        imm = {1'b0, r[5] && (f3 == 3'd5), 5'b0, imm[4:0]};  // Shamt, SRAI bit
      return iOp(imm, f3, rd, rs1);
    end
    return rOp({1'b0, r[5] && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, f3, rd, rs1, rs2);
  endfunction

  // Encodings outside the supported set
  function automatic logic [31:0] badInstr();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return {r[31:7], 7'b0000011};                  // Load
      2'd1:    return {r[31:7], 7'b1101111};                  // JAL
      2'd2:    return rOp(7'h01, r[14:12], r[11:7], r[19:15], r[24:20]);  // M extension
      default: return iOp({7'h20, r[24:20]}, 3'd1, r[11:7], r[19:15]);    // SLLI, bad funct7
    endcase
  endfunction

  // Present one word until it is taken, hold cycles in front of it
  task automatic issue(input logic [31:0] word);
    expWb_t e;
    while (chance(holdPct)) begin
      @(posedge clk);
      hold       <= 1'b1;
      instrValid <= 1'b1;
      instr      <= ~word;  // Must be ignored under hold
      holdCycles++;
    end
    @(posedge clk);
    hold       <= 1'b0;
    instrValid <= 1'b1;
    instr      <= word;
    sent++;
    e = refExecute(word);
    if (e.legal) expQ.push_back(e);
    else illegalSent++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      hold       <= 1'b0;
      instrValid <= 1'b0;
      instr      <= $random(seed);  // Junk, no strobe
      gapCycles++;
    end
  endtask

  task automatic startTest();
    testsRun++;
    errStart    = errors;
    sentStart   = sent;
    illegalSent = 0;
    illegalSeen = 0;
    holdPct     = 0;
  endtask

  task automatic finishTest(input string name);
    @(posedge clk);
    hold       <= 1'b0;
    instrValid <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);  // Watchdog bounds this
    @(posedge clk);                           // Last illegal pulse has been seen
    assert (illegalSeen == illegalSent) else begin
      $display("ERROR illegal pulses: got %h, expected %h", illegalSeen, illegalSent);
      errors++;
    end
    if (errors != errStart) testsFailed++;
    $display("%-12s %4d words  %0d errors", name, sent - sentStart, errors - errStart);
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(negedge clk) begin
    expWb_t e;
    if (!rst && illegal) illegalSeen++;
    if (!rst && wbValid) begin
      assert (expQ.size() != 0) else begin
        $display("Writeback to x%0d arrived with no instruction outstanding", wbRd);
        errors++;
      end
      if (expQ.size() != 0) begin
        e = expQ.pop_front();
        checks++;
        assert (wbRd == e.rd) else begin
          $display("ERROR wbRd: got %h, expected %h", wbRd, e.rd);
          errors++;
        end
        assert (wbData == e.data) else begin
          $display("ERROR wbData: got %h, expected %h (x%0d)", wbData, e.data, e.rd);
          errors++;
        end
      end
    end
  end

  // Budget grows with every driven cycle, plus slack for each drain
  initial begin
    do begin
      @(posedge clk);
      cycles++;
    end while (cycles <= sent + holdCycles + gapCycles + 20 * (testsRun + 1) + 8);
    $display("Timeout: %0d writebacks still outstanding after %0d cycles", expQ.size(), cycles);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    rst        = 1'b1;
    instrValid = 1'b0;
    hold       = 1'b0;
    instr      = '0;
    modelReset();
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    startTest();  // Every operation on known values
    issue(lui(5'd1, 20'h12345));
    issue(iOp(12'h678, 3'd0, 5'd1, 5'd1));
    issue(lui(5'd2, 20'hfedcb));
    issue(iOp(12'hedd, 3'd0, 5'd2, 5'd2));
    issue(iOp(12'h005, 3'd0, 5'd3, 5'd0));
    idle(3);
    for (int f = 0; f < 8; f++) issue(rOp(7'h00, 3'(f), 5'(4 + f), 5'd1, 5'd2));
    issue(rOp(7'h20, 3'd0, 5'd12, 5'd2, 5'd1));  // SUB
    issue(rOp(7'h20, 3'd5, 5'd13, 5'd2, 5'd3));  // SRA
    for (int f = 0; f < 8; f++)
      issue(iOp((f == 1 || f == 5) ? 12'h007 : 12'h9a5, 3'(f), 5'(14 + f), 5'd2));
    issue(iOp(12'h407, 3'd5, 5'd22, 5'd2));      // SRAI
    finishTest("basic");

    startTest();  // Distance 1 from M, 2 from W, 3 through the regfile bypass
    for (int i = 0; i < 40; i++)
      issue(randInstr(5'(1 + i % 7), 5'(1 + (i + 6) % 7), 5'(1 + (i + 5 - i % 2) % 7)));
    finishTest("dependency");

    startTest();  // x0 written, then read right away and later
    issue(iOp(12'h7ff, 3'd0, 5'd0, 5'd0));
    issue(rOp(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
    issue(lui(5'd0, 20'hfffff));
    issue(rOp(7'h00, 3'd6, 5'd5, 5'd0, 5'd0));
    issue(iOp(12'h001, 3'd0, 5'd6, 5'd0));
    issue(rOp(7'h00, 3'd0, 5'd7, 5'd0, 5'd1));
    idle(3);
    issue(rOp(7'h00, 3'd6, 5'd8, 5'd0, 5'd0));
    finishTest("x0");

    startTest();
    holdPct = 40;
    for (int i = 0; i < 60; i++)
      issue(randInstr(5'(1 + i % 5), 5'(1 + (i + 4) % 5), 5'(1 + (i + 3) % 5)));
    finishTest("hold");

    startTest();
    holdPct = 15;
    for (int i = 0; i < 32; i++) begin
      if (i % 4 == 3) issue(badInstr());
      else issue(randInstr(5'(1 + i % 6), 5'(1 + (i + 5) % 6), 5'(1 + (i + 4) % 6)));
    end
    finishTest("illegal");

    startTest();
    for (int i = 0; i < 300; i++) begin
      if (chance(25)) idle(1 + $unsigned($random(seed)) % 3);
      r = $random(seed);
      issue(randInstr(r[4:0], r[9:5], r[14:10]));
    end
    finishTest("random");

    $display("Tests: %0d run, %0d failed, %0d writebacks checked, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0 && testsFailed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/intCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module intCore (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instrValid,  // One word per strobe
  input  core_pkg::instrWord_u instr,
  input  logic                 hold,        // Pipe freeze
  output logic                 wbValid,
  output logic [`REGAW-1:0]    wbRd,
  output logic [`XLEN-1:0]     wbData,
  output logic                 illegal      // Unsupported word seen
);
  import core_pkg::*;

  ctrl_t   ctrlD, ctrlE, wbCtrl;
  fwdSel_e fwdA, fwdB;

  ////////////////////////////////////////
  // Control and datapath side by side
  ////////////////////////////////////////

  controller c (
    .clk, .rst,
    .instrValid,
    .instr,
    .hold,
    .ctrlD, .ctrlE, .wbCtrl,
    .fwdA, .fwdB,
    .illegal
  );

  datapath dp (
    .clk, .rst,
    .hold,
    .instr,
    .ctrlD, .ctrlE, .wbCtrl,
    .fwdA, .fwdB,
    .wbValid, .wbRd, .wbData
  );

endmodule

`default_nettype wire

//--- controller/controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module controller (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instrValid,  // Strobe for instr
  input  core_pkg::instrWord_u instr,
  input  logic                 hold,
  output core_pkg::ctrl_t      ctrlD, ctrlE,
  output core_pkg::ctrl_t      wbCtrl,      // Writeback copy
  output core_pkg::fwdSel_e    fwdA, fwdB,
  output logic                 illegal
);
  import core_pkg::*;

  ctrl_t             ctrlM;
  logic              legalD;      // Encoding is supported
  logic [`REGAW-1:0] rs1E, rs2E;  // Sources of the Execute instruction

  // Later stage that holds the newest copy of rs, Memory first
  function automatic fwdSel_e pickFwd(input logic [`REGAW-1:0] rs,
                                      input ctrl_t ctrlMem, input ctrl_t ctrlWb);
    if (ctrlMem.valid && ctrlMem.regWrite && (ctrlMem.rd != '0) && (ctrlMem.rd == rs))
      return FROMM;
    else if (ctrlWb.valid && ctrlWb.regWrite && (ctrlWb.rd != '0) && (ctrlWb.rd == rs))
      return FROMW;
    else
      return NONE;
  endfunction

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    ctrlD    = '0;
    legalD   = 1'b1;
    ctrlD.rd = instr.rType.rd;
    case (instr.rType.opcode)
      opcodeOp: begin
        case ({instr.rType.funct7, instr.rType.funct3})
          {funct7Base, 3'b000}: ctrlD.aluOp = ADD;
          {funct7Alt,  3'b000}: ctrlD.aluOp = SUB;
          {funct7Base, 3'b001}: ctrlD.aluOp = SLL;
          {funct7Base, 3'b010}: ctrlD.aluOp = SLT;
          {funct7Base, 3'b011}: ctrlD.aluOp = SLTU;
          {funct7Base, 3'b100}: ctrlD.aluOp = XOR;
          {funct7Base, 3'b101}: ctrlD.aluOp = SRL;
          {funct7Alt,  3'b101}: ctrlD.aluOp = SRA;
          {funct7Base, 3'b110}: ctrlD.aluOp = OR;
          {funct7Base, 3'b111}: ctrlD.aluOp = AND;
          default:              legalD = 1'b0;
        endcase
      end
      opcodeOpImm: begin
        ctrlD.aluSrcB = 1'b1;
        case (instr.rType.funct3)
          3'b000: ctrlD.aluOp = ADD;
          3'b010: ctrlD.aluOp = SLT;
          3'b011: ctrlD.aluOp = SLTU;
          3'b100: ctrlD.aluOp = XOR;
          3'b110: ctrlD.aluOp = OR;
          3'b111: ctrlD.aluOp = AND;
          3'b001: begin  // SLLI, upper bits must be clear
            ctrlD.aluOp = SLL;
            legalD      = (instr.rType.funct7 == funct7Base);
          end
          default: begin  // SRLI or SRAI
            ctrlD.aluOp = (instr.rType.funct7 == funct7Alt) ? SRA : SRL;
            legalD      = (instr.rType.funct7 == funct7Base) ||
                          (instr.rType.funct7 == funct7Alt);
          end
        endcase
      end
      opcodeLui: begin
        ctrlD.aluOp    = PASSB;
        ctrlD.aluSrcB  = 1'b1;
        ctrlD.immUpper = 1'b1;
      end
      default: legalD = 1'b0;
    endcase
    ctrlD.regWrite = legalD;                // Every supported form writes rd
    ctrlD.valid    = instrValid && legalD;  // Unsupported word becomes a bubble
  end

  ////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlE   <= '0;
      ctrlM   <= '0;
      wbCtrl  <= '0;
      rs1E    <= '0;
      rs2E    <= '0;
      illegal <= 1'b0;
    end else begin
      illegal <= instrValid && !hold && !legalD;  // Single pulse even if hold follows
      if (!hold) begin
        ctrlE  <= ctrlD;
        ctrlM  <= ctrlE;
        wbCtrl <= ctrlM;
        rs1E   <= instr.rType.rs1;
        rs2E   <= instr.rType.rs2;
      end
    end
  end

  assign fwdA = pickFwd(rs1E, ctrlM, wbCtrl);
  assign fwdB = pickFwd(rs2E, ctrlM, wbCtrl);  // Ignored by the datapath for immediates

  // Stage state must be fully known once reset is released
  aFwdKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(fwdA))
    else $error("fwdA unknown after reset");

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module datapath (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hold,          // Freezes all stages
  input  core_pkg::instrWord_u instr,         // Word in Decode
  input  core_pkg::ctrl_t      ctrlD,         // Decode control, for the immediate form
  input  core_pkg::ctrl_t      ctrlE,
  input  core_pkg::ctrl_t      wbCtrl,        // Writeback stage control
  input  core_pkg::fwdSel_e    fwdA, fwdB,
  output logic                 wbValid,
  output logic [`REGAW-1:0]    wbRd,
  output logic [`XLEN-1:0]     wbData
);
  import core_pkg::*;

  // Decode
  logic [`XLEN-1:0] r1D, r2D;        // Register file read data
  logic [`XLEN-1:0] immExtD;
  // Execute
  logic [`XLEN-1:0] r1E, r2E;
  logic [`XLEN-1:0] immExtE;
  logic [`XLEN-1:0] srcAE, srcBE;    // ALU operands
  logic [`XLEN-1:0] fwdSrcBE;        // Forwarded B before immediate select
  logic [`XLEN-1:0] aluResultE;
  // Memory and Writeback
  logic [`XLEN-1:0] resultM;
  logic [`XLEN-1:0] resultW;
  logic             regWriteW;

  // Operand from the register file or a later stage
  function automatic logic [`XLEN-1:0] fwdMux(input fwdSel_e sel,
                                              input logic [`XLEN-1:0] regVal);
    case (sel)
      FROMM:   return resultM;  // Newest value wins
      FROMW:   return resultW;
      default: return regVal;
    endcase
  endfunction

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  regfile regf (
    .clk, .rst,
    .we  (regWriteW),
    .ra1 (instr.rType.rs1),
    .ra2 (instr.rType.rs2),   // Immediate bits for I-type, ignored later
    .wa  (wbCtrl.rd),
    .wd  (resultW),
    .rd1 (r1D),
    .rd2 (r2D)
  );

  immExtend ext (.instr, .immUpper(ctrlD.immUpper), .immExt(immExtD));

  // Decode to Execute payload
  always_ff @(posedge clk) begin
    if (!hold) begin
      r1E     <= r1D;
      r2E     <= r2D;
      immExtE <= immExtD;
    end
  end

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  always_comb begin
    srcAE    = fwdMux(fwdA, r1E);
    fwdSrcBE = fwdMux(fwdB, r2E);
    srcBE    = ctrlE.aluSrcB ? immExtE : fwdSrcBE;  // Immediate forms and LUI
  end

  alu alu (.srcA(srcAE), .srcB(srcBE), .aluOp(ctrlE.aluOp), .result(aluResultE));

  ////////////////////////////////////////
  // Memory and Writeback
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!hold) begin
      resultM <= aluResultE;
      resultW <= resultM;  // Nothing to add in Memory without loads
    end
  end

  // Held result must not be written or reported twice
  assign regWriteW = wbCtrl.valid && wbCtrl.regWrite && !hold;

  assign wbValid = regWriteW;
  assign wbRd    = wbCtrl.rd;
  assign wbData  = resultW;

  // A result bound for x0 carries real ALU data and must never feed an operand
  aX0Stays: assert property (@(posedge clk) disable iff (rst)
    ((fwdA == FROMW) || (fwdB == FROMW)) |-> (wbCtrl.rd != '0))
    else $error("x0 result forwarded from Writeback");

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module alu (
  input  logic [`XLEN-1:0] srcA,
  input  logic [`XLEN-1:0] srcB,
  input  core_pkg::aluOp_e aluOp,
  output logic [`XLEN-1:0] result
);
  import core_pkg::*;

  logic [`XLEN-1:0] sum, diff;
  logic [4:0]       shamt;       // RV32 shift amount
  logic             ltSigned;
  logic             ltUnsigned;

  ////////////////////////////////////////
  // Arithmetic and compare
  ////////////////////////////////////////

  assign sum  = srcA + srcB;
  assign diff = srcA - srcB;

  assign ltSigned   = $signed(srcA) < $signed(srcB);  // SLT, SLTI
  assign ltUnsigned = srcA < srcB;                    // SLTU, SLTIU

  // Only the low five bits of B count, also for the immediate forms
  assign shamt = srcB[4:0];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (aluOp)
      ADD:     result = sum;
      SUB:     result = diff;
      AND:     result = srcA & srcB;
      OR:      result = srcA | srcB;
      XOR:     result = srcA ^ srcB;
      SLT:     result = {{(`XLEN-1){1'b0}}, ltSigned};
      SLTU:    result = {{(`XLEN-1){1'b0}}, ltUnsigned};
      SLL:     result = srcA << shamt;
      SRL:     result = srcA >> shamt;
      SRA:     result = $signed(srcA) >>> shamt;  // Sign fills from the left
      PASSB:   result = srcB;                      // LUI
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/immExtend.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module immExtend (
  input  core_pkg::instrWord_u instr,
  input  logic                 immUpper,  // LUI form
  output logic [`XLEN-1:0]     immExt
);

  logic [`XLEN-1:0] immI;  // OP-IMM immediate
  logic [`XLEN-1:0] immU;  // LUI immediate

  ////////////////////////////////////////
  // I-type
  ////////////////////////////////////////

  // Sign bit is instruction bit 31
  assign immI = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};

  ////////////////////////////////////////
  // U-type
  ////////////////////////////////////////

  // Bits 31:12 of the word land in place, low 12 bits zero
  assign immU = {instr.iType.imm12,   // Word bits 31:20
                 instr.iType.rs1,     // Word bits 19:15
                 instr.iType.funct3,  // Word bits 14:12
                 12'b0};

  assign immExt = immUpper ? immU : immI;

endmodule

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,        // Write enable from Writeback
  input  logic [`REGAW-1:0] ra1, ra2,  // Read addresses from Decode
  input  logic [`REGAW-1:0] wa,
  input  logic [`XLEN-1:0]  wd,
  output logic [`XLEN-1:0]  rd1, rd2
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NREGS-1];

  // One read port, with write-through for the register being written this cycle
  function automatic logic [`XLEN-1:0] readPort(input logic [`REGAW-1:0] ra);
    if (ra == '0) return '0;                  // Hardwired zero
    else if (we && (wa == ra)) return wd;     // Same-cycle bypass
    else return regs[ra];
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NREGS; i++) regs[i] <= '0;  // Architectural state starts at zero
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // A write with an unknown address would corrupt an arbitrary register
  aWaKnown: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wa))
    else $error("regfile write with unknown address");

endmodule

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

  ////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0]        funct7;  // Selects SUB and SRA among OP forms
    logic [`REGAW-1:0] rs2;
    logic [`REGAW-1:0] rs1;
    logic [2:0]        funct3;
    logic [`REGAW-1:0] rd;
    logic [6:0]        opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0]       imm12;   // Signed immediate, shamt in low bits for shifts
    logic [`REGAW-1:0] rs1;
    logic [2:0]        funct3;
    logic [`REGAW-1:0] rd;
    logic [6:0]        opcode;
  } iType_t;

  // Same 32 bits, read as R-type or I-type
  typedef union packed {
    rType_t rType;
    iType_t iType;
  } instrWord_u;

  // Major opcodes handled by the core
  localparam logic [6:0] opcodeOp    = 7'b0110011;
  localparam logic [6:0] opcodeOpImm = 7'b0010011;
  localparam logic [6:0] opcodeLui   = 7'b0110111;

  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Alt  = 7'b0100000;  // SUB, SRA, SRAI

  ////////////////////////////////////////
  // Control encodings
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA,
    PASSB  // Source B straight through, used by LUI
  } aluOp_e;

  // Carried alongside the instruction from Decode to Writeback
  typedef struct packed {
    logic              valid;     // Real instruction in this stage
    logic              regWrite;  // Writes rd at Writeback
    logic              aluSrcB;   // 1 picks immediate for ALU source B
    logic              immUpper;  // 1 picks U-type immediate
    aluOp_e            aluOp;
    logic [`REGAW-1:0] rd;
  } ctrl_t;

  // Operand source for Execute
  typedef enum logic [1:0] {
    NONE,   // Register file value captured in Decode
    FROMM,  // Result sitting in Memory
    FROMW   // Result sitting in Writeback
  } fwdSel_e;

endpackage

`default_nettype wire

//--- common/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Integer datapath width, RV32 only
`define XLEN 32

// Architectural register file size
`define NREGS 32

// Bits needed to name one register
`define REGAW 5

`endif
